/* muldiv_unit.f */
+incdir+dv
rtl/rv32m_pkg.sv
rtl/muldiv_bus_pkg.sv
rtl/rv_divider.sv
rtl/rv_multiplier.sv
rtl/result_arbiter.sv
rtl/muldiv_dispatch.sv
rtl/muldiv_unit.sv
dv/muldiv_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= muldiv_tb
FLIST     ?= muldiv_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := TEST FAIL

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# a crash without a closing message also counts as failure
sim: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/muldiv_ref.svh */
// expected results from the RV32M definitions; included inside the testbench module after the imports
`ifndef muldiv_ref_svh
`define muldiv_ref_svh

// result of one RV32M op, 64-bit integer math then the selected word
function automatic logic [31:0] ref_result(input logic [2:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
    longint      sa;
    longint      sb;
    longint      ua;
    longint      ub;
    longint      p;
    logic [63:0] up;
    logic        zero;
    logic        ovf;
    logic [31:0] r;
    sa   = longint'($signed(a));
    sb   = longint'($signed(b));
    ua   = longint'({32'b0, a});
    ub   = longint'({32'b0, b});
    up   = {32'b0, a} * {32'b0, b};
    zero = (b == 32'h0);
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    p    = '0;
    case (op)
        mul: begin
            p = sa * sb;
            r = p[31:0];
        end
        mulh: begin
            p = sa * sb;
            r = p[63:32];
        end
        // rs1 signed, rs2 unsigned, product still fits in 64 bits
        mulhsu: begin
            p = sa * ub;
            r = p[63:32];
        end
        mulhu: r = up[63:32];
        div: begin
            p = (zero || ovf) ? 64'(0) : sa / sb;
            r = zero ? 32'hffff_ffff : (ovf ? 32'h8000_0000 : p[31:0]);
        end
        divu: begin
            p = zero ? 64'(0) : ua / ub;
            r = zero ? 32'hffff_ffff : p[31:0];
        end
        // truncating division, so the remainder keeps the dividend sign
        rem: begin
            p = (zero || ovf) ? 64'(0) : sa % sb;
            r = zero ? a : (ovf ? 32'h0 : p[31:0]);
        end
        default: begin
            p = zero ? 64'(0) : ua % ub;
            r = zero ? a : p[31:0];
        end
    endcase
    return r;
endfunction

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

/* dv/muldiv_tb.sv */
// tags 0..31 are reused only after their response; divides are sent only while div_busy is low
`default_nettype none

module muldiv_tb import rv32m_pkg::*, muldiv_bus_pkg::*; ();

    `include "muldiv_ref.svh"

    localparam int wait_limit = 200;

    logic        clk;
    logic        rst;
    muldiv_req_t req;
    muldiv_rsp_t rsp;
    logic        div_busy;

    // scoreboard, one entry per tag
    logic [xlen-1:0]  exp_value [32];
    int               exp_edge [32];
    bit               exp_is_mul [32];
    bit               exp_pending [32];

    int               cyc = 0;
    int               n_issued;
    int               n_received;
    int               n_checks;
    int               errors;
    logic [xlen-1:0]  rng_state;
    logic [xlen-1:0]  corner_vals [8];
    logic [tag_w-1:0] tag_ptr;
    logic [tag_w-1:0] last_tag;

    muldiv_unit u_dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .rsp      (rsp),
        .div_busy (div_busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [xlen-1:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // roughly one operand in four is a corner value
    function automatic logic [xlen-1:0] next_operand();
        logic [xlen-1:0] r;
        r = rand_word();
        if (r[1:0] == 2'b00)
            return corner_vals[r[4:2]];
        return rand_word();
    endfunction

    // issue one request on the next falling edge and record what should come back
    task automatic send(input logic [2:0] op, input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        logic [tag_w-1:0] t;
        int               k;
        @(negedge clk);
        t = tag_ptr;
        k = 0;
        while (exp_pending[t] && k < 32) begin
            t = t + 5'd1;
            k++;
        end
        if (k == 32) begin
            errors++;
            $display("no free tag left for a new request at %0t", $time);
        end
        tag_ptr        = t + 5'd1;
        last_tag       = t;
        exp_value[t]   = ref_result(op, a, b);
        exp_edge[t]    = cyc + 1;
        exp_is_mul[t]  = !op[2];
        exp_pending[t] = 1'b1;
        n_issued++;
        req.valid  = 1'b1;
        req.funct3 = m_funct3_t'(op);
        req.rs1    = a;
        req.rs2    = b;
        req.tag    = t;
    endtask

    task automatic wait_div_idle();
        int n;
        n = 0;
        @(negedge clk);
        req.valid = 1'b0;
        while (div_busy && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (div_busy) begin
            errors++;
            $display("timeout: div_busy never dropped, next divide is sent anyway");
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clk);
        req.valid = 1'b0;
        while (n_received != n_issued && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (n_received != n_issued) begin
            errors++;
            $display("timeout: %0d responses never arrived", n_issued - n_received);
        end
    endtask

    task automatic end_run();
        $display("checks %0d, errors %0d, issued %0d, received %0d",
                 n_checks, errors, n_issued, n_received);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // compare, values seen here are the ones held since the last edge
    always @(posedge clk) begin
        if (!rst && rsp.valid) begin
            if (!exp_pending[rsp.tag]) begin
                errors++;
                $display("response with tag %0d arrived but none was expected", rsp.tag);
            end else begin
                check_eq("rsp.value", rsp.value, exp_value[rsp.tag]);
                if (exp_is_mul[rsp.tag])
                    check_eq("rsp.valid edge", cyc, exp_edge[rsp.tag] + 2);
                exp_pending[rsp.tag] = 1'b0;
                n_received++;
            end
        end
    end

    initial begin
        logic [xlen-1:0]  w;
        logic [tag_w-1:0] dtag;
        rst        = 1'b1;
        req        = '0;
        n_issued   = 0;
        n_received = 0;
        n_checks   = 0;
        errors     = 0;
        rng_state  = 32'd45;
        tag_ptr    = '0;
        last_tag   = '0;
        corner_vals = '{32'h0, 32'h1, 32'h2, 32'hffff_ffff,
                        32'h8000_0000, 32'h7fff_ffff, 32'hffff_fffe, 32'h8000_0001};
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_eq("rsp.valid", 32'(rsp.valid), 32'd0);
        check_eq("div_busy", 32'(div_busy), 32'd0);

        // multiply corners, back to back
        for (int op = 0; op < 4; op++) begin
            send(3'(op), 32'h8000_0000, 32'hffff_ffff);
            send(3'(op), 32'h8000_0000, 32'h8000_0000);
            send(3'(op), 32'hffff_ffff, 32'hffff_ffff);
            send(3'(op), 32'hffff_ffff, 32'h7fff_ffff);
        end
        repeat (64) begin
            w = rand_word();
            send({1'b0, w[1:0]}, next_operand(), next_operand());
        end

        // random divides
        repeat (32) begin
            w = rand_word();
            wait_div_idle();
            send({1'b1, w[1:0]}, next_operand(), next_operand());
        end
        // divide by zero and signed overflow
        for (int op = 4; op < 8; op++) begin
            wait_div_idle();
            send(3'(op), next_operand(), 32'h0);
            wait_div_idle();
            send(3'(op), 32'h8000_0000, 32'hffff_ffff);
        end

        // divide finishes inside a multiply stream and has to wait
        wait_div_idle();
        send(div, rand_word(), rand_word() | 32'h1);
        dtag = last_tag;
        repeat (48) begin
            w = rand_word();
            send({1'b0, w[1:0]}, next_operand(), next_operand());
            if (exp_pending[dtag])
                check_eq("div_busy", 32'(div_busy), 32'd1);
        end
        check_eq("divide held past stream", 32'(exp_pending[dtag]), 32'd1);

        wait_drain();
        check_eq("outstanding", n_issued - n_received, 32'd0);
        end_run();
    end

endmodule

`default_nettype wire

/* rtl/muldiv_unit.sv */
// RV32M mul/div unit; no flush, no back-pressure on rsp, the issuer must hold divides while div_busy
`default_nettype none

module muldiv_unit import muldiv_bus_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  muldiv_req_t  req,
    output muldiv_rsp_t  rsp,
    output logic         div_busy
);

    muldiv_req_t mul_req;
    muldiv_req_t div_req;
    muldiv_rsp_t mul_rsp;
    muldiv_rsp_t div_rsp;
    logic        div_running;
    logic        pending_full;

    muldiv_dispatch u_dispatch (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .div_running  (div_running),
        .pending_full (pending_full),
        .mul_req      (mul_req),
        .div_req      (div_req),
        .div_busy     (div_busy)
    );

    rv_multiplier u_multiplier (
        .clk     (clk),
        .rst     (rst),
        .mul_req (mul_req),
        .mul_rsp (mul_rsp)
    );

    rv_divider u_divider (
        .clk         (clk),
        .rst         (rst),
        .div_req     (div_req),
        .div_running (div_running),
        .div_rsp     (div_rsp)
    );

    // single writeback port shared by both units
    result_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .mul_rsp      (mul_rsp),
        .div_rsp      (div_rsp),
        .rsp          (rsp),
        .pending_full (pending_full)
    );

endmodule

`default_nettype wire

/* rtl/muldiv_dispatch.sv */
// divides arriving while div_busy is high are silently dropped; multiplies always pass
`default_nettype none

module muldiv_dispatch import muldiv_bus_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  muldiv_req_t  req,
    input  logic         div_running,
    input  logic         pending_full,
    output muldiv_req_t  mul_req,
    output muldiv_req_t  div_req,
    output logic         div_busy
);

    logic is_div;
    logic busy_q;

    // funct3 bit 2 selects the divider
    assign is_div = req.funct3[2];

    always_comb begin
        mul_req       = req;
        mul_req.valid = req.valid && !is_div;

        div_req       = req;
        div_req.valid = req.valid && is_div && !busy_q;
    end

    // rises right after an accept, before the divider reports running;
    // stays up one cycle past the last busy source
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= div_req.valid || div_running || pending_full;
        end
    end

    assign div_busy = busy_q;

    // registered busy must still cover a running divider and a held result
    a_no_start_while_busy : assert property (
        @(posedge clk) disable iff (rst)
        div_req.valid |-> !div_running && !pending_full
    );

endmodule

`default_nettype wire

/* rtl/result_arbiter.sv */
// multiplier always wins the port; only one divider result can wait, the issuer must respect busy
`default_nettype none

module result_arbiter import rv32m_pkg::*, muldiv_bus_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  muldiv_rsp_t  mul_rsp,
    input  muldiv_rsp_t  div_rsp,
    output muldiv_rsp_t  rsp,
    output logic         pending_full
);

    logic              pend_full_q;
    logic [xlen-1:0]   pend_value;
    logic [tag_w-1:0]  pend_tag;

    // divider side candidate, held entry first
    muldiv_rsp_t       slot;

    always_comb begin
        slot = div_rsp;
        if (pend_full_q) begin
            slot.valid = 1'b1;
            slot.value = pend_value;
            slot.tag   = pend_tag;
        end
    end

    // fixed priority
    always_comb begin
        if (mul_rsp.valid) begin
            rsp = mul_rsp;
        end else begin
            rsp = slot;
        end
    end

    // slot stays occupied only while a multiply result takes the port
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_full_q <= 1'b0;
        end else begin
            pend_full_q <= slot.valid && mul_rsp.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (div_rsp.valid) begin
            pend_value <= div_rsp.value;
            pend_tag   <= div_rsp.tag;
        end
    end

    assign pending_full = pend_full_q;

    // dispatch holds off divides until the slot drains, so a second result never lands on it
    a_no_overwrite : assert property (
        @(posedge clk) disable iff (rst)
        div_rsp.valid |-> !pending_full
    );

endmodule

`default_nettype wire

/* rtl/rv_multiplier.sv */
// fixed 3-register pipeline, result 2 cycles after the request edge; never stalls
`default_nettype none

module rv_multiplier import rv32m_pkg::*, muldiv_bus_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  muldiv_req_t  mul_req,
    output muldiv_rsp_t  mul_rsp
);

    logic                      a_signed;
    logic                      b_signed;

    // stage 1, extended operands
    logic                      s1_valid;
    m_funct3_t                 s1_op;
    logic [tag_w-1:0]          s1_tag;
    logic signed [xlen:0]      s1_a;
    logic signed [xlen:0]      s1_b;

    // stage 2, full product
    logic                      s2_valid;
    m_funct3_t                 s2_op;
    logic [tag_w-1:0]          s2_tag;
    logic signed [prod_w-1:0]  s2_prod;

    logic                      out_valid;
    logic [xlen-1:0]           out_value;
    logic [tag_w-1:0]          out_tag;

    // mulhsu takes rs1 signed, rs2 unsigned
    assign a_signed = (mul_req.funct3 != mulhu);
    assign b_signed = (mul_req.funct3 == mul) || (mul_req.funct3 == mulh);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= mul_req.valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op   <= mul_req.funct3;
        s1_tag  <= mul_req.tag;
        s1_a    <= {a_signed & mul_req.rs1[xlen-1], mul_req.rs1};
        s1_b    <= {b_signed & mul_req.rs2[xlen-1], mul_req.rs2};

        s2_op   <= s1_op;
        s2_tag  <= s1_tag;
        s2_prod <= s1_a * s1_b;

        // low word for mul, high word otherwise
        out_tag <= s2_tag;
        if (s2_op == mul) begin
            out_value <= s2_prod[xlen-1:0];
        end else begin
            out_value <= s2_prod[2*xlen-1:xlen];
        end
    end

    always_comb begin
        mul_rsp.valid = out_valid;
        mul_rsp.value = out_value;
        mul_rsp.tag   = out_tag;
    end

endmodule

`default_nettype wire

/* rtl/rv_divider.sv */
// one divide at a time, 34 cycles or 2 for special cases; a start while not idle is ignored
`default_nettype none

module rv_divider import rv32m_pkg::*, muldiv_bus_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  muldiv_req_t  div_req,
    output logic         div_running,
    output muldiv_rsp_t  div_rsp
);

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_done
    } div_state_t;

    div_state_t state;

    logic [xlen_log2-1:0] count;
    // remainder in the upper half, quotient shifts in at the bottom
    logic [2*xlen-1:0]    acc;
    logic [xlen-1:0]      divisor_mag;
    logic                 q_neg;
    logic                 r_neg;
    logic                 sel_rem;
    logic [tag_w-1:0]     tag_q;

    logic                 rsp_valid_q;
    logic [xlen-1:0]      rsp_value_q;

    logic                 signed_op;
    logic                 div_zero;
    logic                 overflow;
    logic [xlen-1:0]      dividend_mag;
    logic [xlen-1:0]      divisor_abs;
    logic [xlen:0]        trial;
    logic [xlen-1:0]      quotient;
    logic [xlen-1:0]      remainder;

    // start decode, valid only while idle
    assign signed_op = (div_req.funct3 == div) || (div_req.funct3 == rem);
    assign div_zero  = (div_req.rs2 == '0);
    assign overflow  = signed_op && (div_req.rs1 == int_min) && (div_req.rs2 == '1);

    assign dividend_mag = (signed_op && div_req.rs1[xlen-1]) ? -div_req.rs1 : div_req.rs1;
    assign divisor_abs  = (signed_op && div_req.rs2[xlen-1]) ? -div_req.rs2 : div_req.rs2;

    // 33-bit trial subtract, top bit set means the divisor did not fit
    assign trial = acc[2*xlen-1:xlen-1] - {1'b0, divisor_mag};

    // sign fixup of the magnitudes
    assign quotient  = q_neg ? -acc[xlen-1:0] : acc[xlen-1:0];
    assign remainder = r_neg ? -acc[2*xlen-1:xlen] : acc[2*xlen-1:xlen];

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (div_req.valid) begin
                        // special cases skip the shift loop
                        state <= (div_zero || overflow) ? st_done : st_shift;
                    end
                end
                st_shift: begin
                    if (count == '0) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    state       <= st_idle;
                    rsp_valid_q <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (div_req.valid) begin
                    tag_q   <= div_req.tag;
                    sel_rem <= div_req.funct3 inside {rem, remu};
                    count   <= xlen_log2'(xlen - 1);
                    if (div_zero) begin
                        // quotient all ones, remainder is the dividend
                        acc   <= {div_req.rs1, {xlen{1'b1}}};
                        q_neg <= 1'b0;
                        r_neg <= 1'b0;
                    end else if (overflow) begin
                        acc   <= {{xlen{1'b0}}, int_min};
                        q_neg <= 1'b0;
                        r_neg <= 1'b0;
                    end else begin
                        acc         <= {{xlen{1'b0}}, dividend_mag};
                        divisor_mag <= divisor_abs;
                        q_neg       <= signed_op && (div_req.rs1[xlen-1] ^ div_req.rs2[xlen-1]);
                        // remainder follows the dividend sign
                        r_neg       <= signed_op && div_req.rs1[xlen-1];
                    end
                end
            end
            st_shift: begin
                count <= count - 1'b1;
                if (!trial[xlen]) begin
                    acc <= {trial[xlen-1:0], acc[xlen-2:0], 1'b1};
                end else begin
                    acc <= {acc[2*xlen-2:0], 1'b0};
                end
            end
            st_done: begin
                rsp_value_q <= sel_rem ? remainder : quotient;
            end
            default: begin
                count <= '0;
            end
        endcase
    end

    // busy through the result cycle too
    assign div_running = (state != st_idle) || rsp_valid_q;

    always_comb begin
        div_rsp.valid = rsp_valid_q;
        div_rsp.value = rsp_value_q;
        div_rsp.tag   = tag_q;
    end

    // done never repeats, the result strobe stays a single pulse
    a_done_one_cycle : assert property (
        @(posedge clk) disable iff (rst)
        state == st_done |=> state == st_idle
    );

endmodule

`default_nettype wire

/* rtl/muldiv_bus_pkg.sv */
// request and result transport types; valid is a one-cycle strobe, there is no ready
`default_nettype none

package muldiv_bus_pkg;

    import rv32m_pkg::*;

    // destination register tag, one of 32 integer registers
    localparam int unsigned tag_w = 5;

    typedef struct packed {
        logic              valid;
        m_funct3_t         funct3;
        logic [xlen-1:0]   rs1;
        logic [xlen-1:0]   rs2;
        logic [tag_w-1:0]  tag;
    } muldiv_req_t;

    // one result per request, carrying the request's tag back
    typedef struct packed {
        logic              valid;
        logic [xlen-1:0]   value;
        logic [tag_w-1:0]  tag;
    } muldiv_rsp_t;

endpackage

`default_nettype wire

/* rtl/rv32m_pkg.sv */
// RV32M ISA definitions only; the datapath width is fixed at 32 bits by the ISA
`default_nettype none

package rv32m_pkg;

    // operand and result width
    localparam int unsigned xlen = 32;

    // bits needed to count the divider steps
    localparam int unsigned xlen_log2 = $clog2(xlen);

    // full signed product of two 33-bit extended operands
    localparam int unsigned prod_w = 2 * xlen + 2;

    // most negative signed value, the dividend of the overflow case
    localparam logic [xlen-1:0] int_min = {1'b1, {(xlen - 1){1'b0}}};

    // funct3 of the OP major opcode with funct7 = 0000001
    // bit 2 splits multiply from divide
    typedef enum logic [2:0] {
        mul    = 3'b000,
        mulh   = 3'b001,
        mulhsu = 3'b010,
        mulhu  = 3'b011,
        div    = 3'b100,
        divu   = 3'b101,
        rem    = 3'b110,
        remu   = 3'b111
    } m_funct3_t;

endpackage

`default_nettype wire
